/* common/stream_pkg.sv */
// Stream package with the widths, vector types and word records of the byte packer path
package stream_pkg;

	//////////////////////////////
	// Widths and depths
	//////////////////////////////

	// One input byte
	localparam int BYTE_W     = 8;
	// Byte lanes in one packed word
	localparam int WORD_BYTES = 4;
	// FIFO memory address width
	localparam int FIFO_AW    = 4;
	// Entries in the FIFO, 16
	localparam int FIFO_DEPTH = 1 << FIFO_AW;
	// Running frame sum width, wraps modulo 2^16
	localparam int SUM_W      = 16;

	//////////////////////////////
	// Vector types
	//////////////////////////////

	typedef logic [BYTE_W-1:0]               byte_t;
	typedef logic [WORD_BYTES*BYTE_W-1:0]    word_data_t;
	// Valid byte count minus one
	typedef logic [$clog2(WORD_BYTES)-1:0]   lane_cnt_t;
	// Fill level, one bit wider than the address so 16 fits
	typedef logic [FIFO_AW:0]                fill_t;
	// Pointer with wrap bit on top
	typedef logic [FIFO_AW:0]                ptr_t;
	typedef logic [SUM_W-1:0]                frame_sum_t;

	//////////////////////////////
	// Records
	//////////////////////////////

	// FIFO entry, 35 bits; first byte in the low lane, unused lanes zero
	typedef struct packed {
		word_data_t data;
		lane_cnt_t  lanes;
		logic       last;
	} pack_word_t;

	// Drain output; sum only counts on the last word of a frame
	typedef struct packed {
		pack_word_t word;
		frame_sum_t sum;
	} drain_out_t;

endpackage

/* fifo/sp_fifo_mem.sv */
// FIFO word store, single-port array with registered read and read priority over write
`timescale 1ns/100ps

module sp_fifo_mem import stream_pkg::*; (
	input  logic               i_clk,
	input  logic               i_rd,
	input  logic               i_wr,
	input  logic [FIFO_AW-1:0] i_addr_rd,
	input  logic [FIFO_AW-1:0] i_addr_wr,
	input  pack_word_t         i_wr_data,
	output pack_word_t         o_rd_data
);

	// Storage array, no reset on the contents
	pack_word_t mem [0:FIFO_DEPTH-1];

	// Shared address port
	logic [FIFO_AW-1:0] addr;

	//////////////////////////////
	// Address select
	//////////////////////////////

	// Only one port exists, so the read address wins when both are asked
	assign addr = i_rd ? i_addr_rd : i_addr_wr;

	//////////////////////////////
	// Single access per cycle
	//////////////////////////////

	always_ff @(posedge i_clk) begin
		if (i_rd) begin
			// Read data shows up the next cycle
			o_rd_data <= mem[addr];
		end else if (i_wr) begin
			mem[addr] <= i_wr_data;
		end
	end

endmodule

/* fifo/sp_fifo.sv */
// Synchronous word FIFO over a single-port memory where a read blocks the write slot
`timescale 1ns/100ps

module sp_fifo import stream_pkg::*; (
	input  logic       i_clk,
	input  logic       i_rst_n,
	// Write side
	input  logic       i_wr,
	input  pack_word_t i_wr_word,
	output logic       o_wr_ready,
	output logic       o_full,
	output fill_t      o_fill,
	// Read side
	input  logic       i_rd,
	output pack_word_t o_rd_word,
	output logic       o_empty
);

	// Pointers carry a wrap bit above the address
	ptr_t wr_ptr;
	ptr_t rd_ptr;

	// Accepted transfers
	logic wr_ok;
	logic rd_ok;

	//////////////////////////////
	// Handshake
	//////////////////////////////

	// The memory port is busy whenever a read is asked for
	assign o_wr_ready = !i_rd;

	// Write lands only with room and a free port
	assign wr_ok = i_wr && !o_full && !i_rd;
	assign rd_ok = i_rd && !o_empty;

	//////////////////////////////
	// Pointers
	//////////////////////////////

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (wr_ok)
				wr_ptr <= wr_ptr + 1'b1;
			if (rd_ok)
				rd_ptr <= rd_ptr + 1'b1;
		end
	end

	// Occupancy from the pointer difference, wrap bit makes 16 distinct from 0
	assign o_fill  = wr_ptr - rd_ptr;
	assign o_full  = (o_fill == fill_t'(FIFO_DEPTH));
	assign o_empty = (o_fill == '0);

	//////////////////////////////
	// Memory
	//////////////////////////////

	// Low pointer bits address the array
	sp_fifo_mem u_mem (
		.i_clk     (i_clk),
		.i_rd      (i_rd),
		.i_wr      (i_wr && !o_full),
		.i_addr_rd (rd_ptr[FIFO_AW-1:0]),
		.i_addr_wr (wr_ptr[FIFO_AW-1:0]),
		.i_wr_data (i_wr_word),
		.o_rd_data (o_rd_word)
	);

endmodule

/* logic/byte_packer.sv */
// Byte packer, collects input bytes into word records and holds each word until the FIFO takes it
`timescale 1ns/100ps

module byte_packer import stream_pkg::*; (
	input  logic       i_clk,
	input  logic       i_rst_n,
	// Byte input
	input  logic       i_valid,
	input  byte_t      i_byte,
	input  logic       i_last,
	output logic       o_ready,
	// FIFO write side
	output logic       o_wr,
	output pack_word_t o_word,
	input  logic       i_wr_ready,
	input  logic       i_full
);

	// Next free lane in the word being built
	lane_cnt_t  lane;
	// Bytes gathered so far, upper lanes stay zero
	word_data_t acc;
	// Closed word waiting for the FIFO
	logic       pending;

	logic       take;
	logic       close;
	logic       stored;
	word_data_t acc_next;

	//////////////////////////////
	// Byte accept
	//////////////////////////////

	// No new bytes while a word waits
	assign o_ready = !pending;
	assign take    = i_valid && o_ready;

	// Word ends on the last lane or on end of frame
	assign close = take && (i_last || lane == lane_cnt_t'(WORD_BYTES-1));

	// FIFO takes the word when ready and not full
	assign stored = pending && i_wr_ready && !i_full;

	// Drop the byte into its lane
	always_comb begin
		acc_next = acc;
		acc_next[lane*BYTE_W +: BYTE_W] = i_byte;
	end

	//////////////////////////////
	// Lane counter and pending flag
	//////////////////////////////

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			lane    <= '0;
			acc     <= '0;
			pending <= 1'b0;
		end else begin
			if (close) begin
				// Restart from lane 0 with clean lanes
				lane    <= '0;
				acc     <= '0;
				pending <= 1'b1;
			end else if (take) begin
				lane <= lane + 1'b1;
				acc  <= acc_next;
			end
			if (stored)
				pending <= 1'b0;
		end
	end

	// Word record, loaded only when a word closes so it stays steady while pending
	always_ff @(posedge i_clk) begin
		if (close) begin
			o_word.data  <= acc_next;
			o_word.lanes <= lane;
			o_word.last  <= i_last;
		end
	end

	assign o_wr = pending;

endmodule

/* logic/word_drain.sv */
// Word drain, reads the FIFO under downstream ready and tags frame ends with a byte sum
`timescale 1ns/100ps

module word_drain import stream_pkg::*; (
	input  logic       i_clk,
	input  logic       i_rst_n,
	// FIFO read side
	input  logic       i_empty,
	output logic       o_rd,
	input  pack_word_t i_rd_word,
	// Output side
	input  logic       i_out_ready,
	output logic       o_valid,
	output drain_out_t o_out
);

	// Read issued last cycle, its word is on i_rd_word now
	logic       rd_pend;
	// Sum of the earlier words of the current frame
	frame_sum_t sum_acc;
	// Valid bytes of the word being presented
	frame_sum_t word_sum;
	frame_sum_t sum_total;

	//////////////////////////////
	// Read request
	//////////////////////////////

	// Back to back reads are fine, the memory output is registered
	assign o_rd = !i_empty && i_out_ready;

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n)
			rd_pend <= 1'b0;
		else
			rd_pend <= o_rd;
	end

	assign o_valid = rd_pend;

	//////////////////////////////
	// Frame sum
	//////////////////////////////

	// Add lanes 0 through lanes, zero-extended to the sum width
	always_comb begin
		word_sum = '0;
		for (int i = 0; i < WORD_BYTES; i++) begin
			if (i <= int'(i_rd_word.lanes))
				word_sum = word_sum + frame_sum_t'(i_rd_word.data[i*BYTE_W +: BYTE_W]);
		end
	end

	// Wraps modulo 2^16
	assign sum_total = sum_acc + word_sum;

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			sum_acc <= '0;
		end else if (rd_pend) begin
			// Restart after the last word of a frame
			if (i_rd_word.last)
				sum_acc <= '0;
			else
				sum_acc <= sum_total;
		end
	end

	//////////////////////////////
	// Output record
	//////////////////////////////

	assign o_out.word = i_rd_word;
	assign o_out.sum  = sum_total;

endmodule

/* logic/pack_stream_top.sv */
// Byte stream top, packer feeding a single-port FIFO drained by the word drain
`timescale 1ns/100ps

module pack_stream_top import stream_pkg::*; (
	input  logic       i_clk,
	input  logic       i_rst_n,
	// Byte input side
	input  logic       i_in_valid,
	input  byte_t      i_in_byte,
	input  logic       i_in_last,
	output logic       o_in_ready,
	// Word output side
	input  logic       i_out_ready,
	output logic       o_out_valid,
	output drain_out_t o_out,
	// FIFO occupancy
	output fill_t      o_fill
);

	// Packer to FIFO
	logic       wr_req;
	pack_word_t wr_word;
	logic       wr_ready;
	logic       full;

	// FIFO to drain
	logic       rd_req;
	pack_word_t rd_word;
	logic       empty;

	//////////////////////////////
	// Producer
	//////////////////////////////

	byte_packer u_packer (
		.i_clk      (i_clk),
		.i_rst_n    (i_rst_n),
		.i_valid    (i_in_valid),
		.i_byte     (i_in_byte),
		.i_last     (i_in_last),
		.o_ready    (o_in_ready),
		.o_wr       (wr_req),
		.o_word     (wr_word),
		.i_wr_ready (wr_ready),
		.i_full     (full)
	);

	//////////////////////////////
	// Buffer
	//////////////////////////////

	sp_fifo u_fifo (
		.i_clk      (i_clk),
		.i_rst_n    (i_rst_n),
		.i_wr       (wr_req),
		.i_wr_word  (wr_word),
		.o_wr_ready (wr_ready),
		.o_full     (full),
		.o_fill     (o_fill),
		.i_rd       (rd_req),
		.o_rd_word  (rd_word),
		.o_empty    (empty)
	);

	//////////////////////////////
	// Consumer
	//////////////////////////////

	word_drain u_drain (
		.i_clk       (i_clk),
		.i_rst_n     (i_rst_n),
		.i_empty     (empty),
		.o_rd        (rd_req),
		.i_rd_word   (rd_word),
		.i_out_ready (i_out_ready),
		.o_valid     (o_out_valid),
		.o_out       (o_out)
	);

endmodule

/* tb/pack_stream_chk.sv */
// FIFO checker for occupancy and handshake rules bound into the word FIFO
`timescale 1ns/100ps

module pack_stream_chk import stream_pkg::*; (
	input logic  i_clk,
	input logic  i_rst_n,
	input logic  i_rd,
	input logic  i_full,
	input logic  i_empty,
	input fill_t i_fill,
	input ptr_t  i_wr_ptr
);

	// Count of failed properties
	int fail_cnt = 0;

	//////////////////////////////
	// Occupancy
	//////////////////////////////

	// Never more than 16 words held
	a_fill_max: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		i_fill <= fill_t'(FIFO_DEPTH))
		else begin
			$error("FIFO fill level above its depth");
			fail_cnt++;
		end

	// Flags never overlap and never swap within one cycle since the pointers step by one
	a_flags: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		!(i_empty && (i_full || $past(i_full))) && !(i_full && $past(i_empty)))
		else begin
			$error("FIFO empty and full flags overlapped or swapped in one cycle");
			fail_cnt++;
		end

	//////////////////////////////
	// Handshake
	//////////////////////////////

	// Write pointer holds while full or while the port serves a read
	a_wr_hold: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		(i_full || i_rd) |=> $stable(i_wr_ptr))
		else begin
			$error("FIFO write pointer moved while full or reading");
			fail_cnt++;
		end

	// Drain must not read an empty FIFO
	a_rd_empty: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		!(i_rd && i_empty))
		else begin
			$error("FIFO read requested while empty");
			fail_cnt++;
		end

endmodule

bind sp_fifo pack_stream_chk u_chk (
	.i_clk    (i_clk),
	.i_rst_n  (i_rst_n),
	.i_rd     (i_rd),
	.i_full   (o_full),
	.i_empty  (o_empty),
	.i_fill   (o_fill),
	.i_wr_ptr (wr_ptr)
);

/* tb/tb_pack_stream.sv */
// Testbench for the byte packing stream with reference word model, output compare and watchdog
`timescale 1ns/100ps

module tb_pack_stream import stream_pkg::*; ();

	// Byte budget of all tests for the watchdog
	localparam int RAND_FRAMES  = 40;
	localparam int RAND_MAX_LEN = 40;
	localparam int TOTAL_BYTES  = 24 + 17 + 70 + 633 + RAND_FRAMES * RAND_MAX_LEN;
	localparam int WATCHDOG_CYC = TOTAL_BYTES * 64 + 1000;

	logic       i_clk;
	logic       i_rst_n     = 1'b0;
	logic       i_in_valid  = 1'b0;
	byte_t      i_in_byte   = '0;
	logic       i_in_last   = 1'b0;
	logic       i_out_ready = 1'b1;
	logic       o_in_ready;
	logic       o_out_valid;
	drain_out_t o_out;
	fill_t      o_fill;

	// Bytes waiting to go out with the last flag on top
	logic [8:0] send_q[$];
	// Current frame and the records it should give
	byte_t      frame_q[$];
	drain_out_t exp_q[$];
	drain_out_t exp_rec;

	integer      seed = 32'he283_38b2;
	logic [31:0] rnd_word;
	logic        ready_rand  = 1'b0;
	logic        ready_level = 1'b1;
	int          checks = 0;
	int          fails = 0;
	int          fails_start = 0;
	int          tests_run = 0;
	int          words_seen = 0;
	int          chk_fails;

	pack_stream_top DUT (
		.i_clk       (i_clk),
		.i_rst_n     (i_rst_n),
		.i_in_valid  (i_in_valid),
		.i_in_byte   (i_in_byte),
		.i_in_last   (i_in_last),
		.o_in_ready  (o_in_ready),
		.i_out_ready (i_out_ready),
		.o_out_valid (o_out_valid),
		.o_out       (o_out),
		.o_fill      (o_fill)
	);

	initial begin
		i_clk = 1'b0;
		forever #4 i_clk = ~i_clk;
	end

	//////////////////////////////
	// Reference model and checks
	//////////////////////////////

	// Split frame_q into word records low lane first with the frame sum on the last word
	function automatic void model_frame();
		drain_out_t rec;
		frame_sum_t sum;
		int         n;
		rec = '0;
		sum = '0;
		n = 0;
		for (int i = 0; i < frame_q.size(); i++) begin
			rec.word.data[n*BYTE_W +: BYTE_W] = frame_q[i];
			sum = sum + frame_sum_t'(frame_q[i]);
			n++;
			if (n == WORD_BYTES || i == frame_q.size() - 1) begin
				rec.word.lanes = lane_cnt_t'(n - 1);
				rec.word.last  = (i == frame_q.size() - 1);
				rec.sum        = rec.word.last ? sum : '0;
				exp_q.push_back(rec);
				rec = '0;
				n = 0;
			end
		end
	endfunction

	task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] want);
		checks++;
		assert (got === want) else begin
			$display("MISMATCH at %0t: %s got %0h expected %0h", $time, name, got, want);
			fails++;
		end
	endtask

	// Kind 0 counts up from base and 1 is all 0xFF while others are random
	task automatic queue_frame(input int len, input int kind, input byte_t base);
		byte_t b;
		frame_q.delete();
		for (int i = 0; i < len; i++) begin
			case (kind)
				0:       b = base + byte_t'(i);
				1:       b = 8'hFF;
				default: b = byte_t'($random(seed));
			endcase
			frame_q.push_back(b);
		end
		model_frame();
		for (int i = 0; i < len; i++)
			send_q.push_back({(i == len - 1), frame_q[i]});
	endtask

	// Everything sent and every expected word seen
	task automatic wait_idle();
		while (send_q.size() != 0 || exp_q.size() != 0)
			@(posedge i_clk);
		repeat (4) @(posedge i_clk);
	endtask

	task automatic report_test(input int num, input string name);
		tests_run++;
		$display("Test %0d %s: %s, %0d failed checks", num, name,
			(fails == fails_start) ? "ok" : "FAILED", fails - fails_start);
		fails_start = fails;
	endtask

	//////////////////////////////
	// Input feeder
	//////////////////////////////

	always @(posedge i_clk) begin
		if (i_rst_n) begin
			// Byte on the bus was taken at this edge
			if (i_in_valid && o_in_ready)
				void'(send_q.pop_front());
			if (send_q.size() > 0) begin
				i_in_valid <= 1'b1;
				i_in_byte  <= send_q[0][7:0];
				i_in_last  <= send_q[0][8];
			end else begin
				i_in_valid <= 1'b0;
				i_in_last  <= 1'b0;
			end
		end
		// Downstream ready is random at half density in the random test
		if (ready_rand) begin
			rnd_word = $random(seed);
			i_out_ready <= rnd_word[0];
		end else begin
			i_out_ready <= ready_level;
		end
	end

	// Output compare sampled mid-cycle where o_out is settled
	always @(negedge i_clk) begin
		if (i_rst_n && o_out_valid) begin
			if (exp_q.size() == 0) begin
				$display("Unexpected output word at %0t, no word was due", $time);
				fails++;
			end else begin
				exp_rec = exp_q.pop_front();
				check_val("o_out.word", 64'(o_out.word), 64'(exp_rec.word));
				// Sum only holds on the frame's last word
				if (exp_rec.word.last)
					check_val("o_out.sum", 64'(o_out.sum), 64'(exp_rec.sum));
				words_seen++;
			end
		end
	end

	initial begin
		repeat (WATCHDOG_CYC) @(posedge i_clk);
		$display("Timeout after %0d cycles, output words stopped coming", WATCHDOG_CYC);
		$display("Errors found");
		$finish;
	end

	//////////////////////////////
	// Test sequence
	//////////////////////////////

	initial begin
		int          len;
		int          cyc;
		logic [31:0] rnd_len;
		repeat (16) @(posedge i_clk);
		i_rst_n <= 1'b1;

		@(negedge i_clk);
		check_val("o_out_valid", 64'(o_out_valid), 64'd0);
		check_val("o_in_ready", 64'(o_in_ready), 64'd1);
		check_val("o_fill", 64'(o_fill), 64'd0);
		report_test(1, "reset state");

		queue_frame(4, 0, 8'h10);
		queue_frame(8, 0, 8'h20);
		queue_frame(12, 0, 8'hF8);
		wait_idle();
		report_test(2, "full word frames");

		queue_frame(1, 0, 8'h01);
		queue_frame(2, 0, 8'h11);
		queue_frame(3, 0, 8'h21);
		queue_frame(5, 0, 8'h31);
		queue_frame(6, 0, 8'h41);
		wait_idle();
		report_test(3, "partial word frames");

		// Stall the drain until the FIFO is full and the packer blocks
		ready_level = 1'b0;
		repeat (2) @(posedge i_clk);
		queue_frame(70, 0, 8'h40);
		cyc = 0;
		while (o_fill != fill_t'(FIFO_DEPTH) && cyc < 200) begin
			@(posedge i_clk);
			cyc++;
		end
		repeat (10) @(posedge i_clk);
		@(negedge i_clk);
		check_val("o_fill", 64'(o_fill), 64'(FIFO_DEPTH));
		check_val("o_in_ready", 64'(o_in_ready), 64'd0);
		ready_level = 1'b1;
		wait_idle();
		report_test(4, "back-pressure");

		// 600 x 0xFF wraps the 16-bit sum
		queue_frame(600, 1, 8'h00);
		queue_frame(33, 0, 8'h80);
		wait_idle();
		report_test(5, "frame sums");

		for (int f = 0; f < RAND_FRAMES; f++) begin
			rnd_len = $random(seed);
			len = 1 + int'(rnd_len % 32'(RAND_MAX_LEN));
			queue_frame(len, 2, 8'h00);
		end
		ready_rand = 1'b1;
		wait_idle();
		ready_rand = 1'b0;
		report_test(6, "random frames");

		chk_fails = DUT.u_fifo.u_chk.fail_cnt;
		$display("Tests %0d, checks %0d, failed checks %0d, assertion failures %0d, words %0d",
			tests_run, checks, fails, chk_fails, words_seen);
		if (fails == 0 && chk_fails == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

endmodule

/* tb.f */
common/stream_pkg.sv
fifo/sp_fifo_mem.sv
fifo/sp_fifo.sv
logic/byte_packer.sv
logic/word_drain.sv
logic/pack_stream_top.sv
tb/pack_stream_chk.sv
tb/tb_pack_stream.sv

/* Makefile */
# Verilator build and run of the byte packing stream testbench

SRCS := $(filter-out +%,$(shell cat tb.f))

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
obj_dir/Vtb_pack_stream: tb.f $(SRCS)
	verilator --binary --timing --assert --top-module tb_pack_stream -f tb.f

# Pass or fail comes from the pass message in the log
run: obj_dir/Vtb_pack_stream
	./obj_dir/Vtb_pack_stream | tee sim.log
	grep -qx "No errors" sim.log

clean:
	rm -rf obj_dir sim.log
